/* booth_mul_params.svh */
//----------------------------
// width settings of the booth multiplier
// include once, ahead of the package, to pick the operand width
// the operand width must be twice a power of two, at least 8
//----------------------------
`ifndef BOOTH_MUL_PARAMS_SVH
`define BOOTH_MUL_PARAMS_SVH

// operand width in bits
`define BOOTH_MUL_WIDTH 32

// full signed product width
`define BOOTH_MUL_PROD_WIDTH (2 * `BOOTH_MUL_WIDTH)

// one radix-4 partial product per two multiplier bits
`define BOOTH_MUL_NUM_PP (`BOOTH_MUL_WIDTH / 2)

`endif

/* booth_mul_pkg.sv */
//----------------------------
// shared types of the booth multiplier datapath
// referenced by scoped name from every module of the design
//----------------------------
`include "booth_mul_params.svh"

package booth_mul_pkg;

    localparam int WIDTH      = `BOOTH_MUL_WIDTH;
    localparam int PROD_WIDTH = `BOOTH_MUL_PROD_WIDTH;
    localparam int NUM_PP     = `BOOTH_MUL_NUM_PP;

    //----------------------------
    // scalar payloads
    //----------------------------
    typedef logic signed [WIDTH-1:0]      operand_t;
    typedef logic signed [PROD_WIDTH-1:0] product_t;

    // request payload, captured as one word pair
    typedef struct packed {
        operand_t multiplicand;
        operand_t multiplier;
    } mul_operands_t;

    // redundant sum/carry form out of a compressor row
    // carry already sits at its own weight
    typedef struct packed {
        product_t sum;
        product_t carry;
    } csa_pair_t;

    // all shifted partial products, entry i has weight 4**i
    typedef product_t [NUM_PP-1:0] pp_array_t;

endpackage

/* booth_encoder.sv */
//----------------------------
// radix-4 booth recoding of the multiplier
// produces every partial product already shifted and sign-extended
// to product width, ready for the compressor tree
//----------------------------
`timescale 1ns/1ps

module booth_encoder (
    input  booth_mul_pkg::operand_t  multiplicand_i,
    input  booth_mul_pkg::operand_t  multiplier_i,
    output booth_mul_pkg::pp_array_t pp_o
);

    localparam int W      = booth_mul_pkg::WIDTH;
    localparam int NUM_PP = booth_mul_pkg::NUM_PP;

    // multiplier with the implicit zero below bit 0
    logic [W:0] mult_ext;

    assign mult_ext = {multiplier_i, 1'b0};

    for (genvar i = 0; i < NUM_PP; i++) begin : g_pp
        logic [2:0]                grp;
        logic                      neg;
        logic signed [W:0]         mag;
        logic signed [W:0]         inv;
        booth_mul_pkg::product_t   ext;

        // overlapping group of three bits, centred on bit 2*i
        assign grp = mult_ext[2*i+2 -: 3];

        // magnitude select: 0, 1x or 2x the multiplicand
        always_comb begin
            unique case (grp)
                3'b001, 3'b010, 3'b101, 3'b110: begin
                    mag = {multiplicand_i[W-1], multiplicand_i};
                end
                3'b011, 3'b100: begin
                    mag = {multiplicand_i, 1'b0};
                end
                default: begin
                    mag = '0;
                end
            endcase
        end

        // negative digits for the upper half of the code table
        assign neg = grp[2];

        // ones complement here, the +1 is added after extension
        // so that -2x of the most negative value still fits
        assign inv = mag ^ {(W + 1){neg}};
        assign ext = booth_mul_pkg::product_t'(inv) + booth_mul_pkg::product_t'(neg);

        // weight of digit i is 4**i
        assign pp_o[i] = ext << (2 * i);
    end

endmodule

/* compressor42.sv */
//----------------------------
// one product-wide row of 4:2 compressors
// four addends in, one sum/carry pair out with the same total
// modulo the product width
//----------------------------
`timescale 1ns/1ps

module compressor42 (
    input  booth_mul_pkg::product_t  in0_i,
    input  booth_mul_pkg::product_t  in1_i,
    input  booth_mul_pkg::product_t  in2_i,
    input  booth_mul_pkg::product_t  in3_i,
    output booth_mul_pkg::csa_pair_t pair_o
);

    localparam int PW = booth_mul_pkg::PROD_WIDTH;

    logic [PW-1:0] fa1_sum;
    logic [PW-1:0] fa1_carry;
    logic [PW-1:0] lat_cin;
    logic [PW-1:0] fa2_carry;

    //----------------------------
    // first full adder per bit
    //----------------------------
    assign fa1_sum   = in0_i ^ in1_i ^ in2_i;
    assign fa1_carry = (in0_i & in1_i) | (in0_i & in2_i) | (in1_i & in2_i);

    // intermediate carry moves one bit up, top one falls off
    assign lat_cin = {fa1_carry[PW-2:0], 1'b0};

    //----------------------------
    // second full adder per bit
    //----------------------------
    assign pair_o.sum = fa1_sum ^ in3_i ^ lat_cin;
    assign fa2_carry  = (fa1_sum & in3_i) | (fa1_sum & lat_cin) | (in3_i & lat_cin);

    // carry vector leaves at its real weight
    assign pair_o.carry = {fa2_carry[PW-2:0], 1'b0};

endmodule

/* wallace_tree.sv */
//----------------------------
// wallace tree of 4:2 compressor rows
// reduces all partial products to one sum/carry pair,
// first level four partial products per row, later levels two pairs per row
//----------------------------
`timescale 1ns/1ps

module wallace_tree (
    input  booth_mul_pkg::pp_array_t pp_i,
    output booth_mul_pkg::csa_pair_t pair_o
);

    localparam int NUM_PP = booth_mul_pkg::NUM_PP;
    // rows in the first level
    localparam int ROWS0  = NUM_PP / 4;
    localparam int LEVELS = $clog2(NUM_PP) - 1;
    localparam int NODES  = 2 * ROWS0 - 1;

    // every row output of every level, stored level after level
    // level l starts at 2*ROWS0 - 2*(ROWS0 >> l)
    booth_mul_pkg::csa_pair_t node [NODES];

    for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
        localparam int ROWS = ROWS0 >> l;
        localparam int OFS  = 2 * ROWS0 - 2 * ROWS;

        for (genvar r = 0; r < ROWS; r++) begin : g_row
            if (l == 0) begin : g_first
                compressor42 i_cpr (
                    .in0_i  (pp_i[4*r]),
                    .in1_i  (pp_i[4*r+1]),
                    .in2_i  (pp_i[4*r+2]),
                    .in3_i  (pp_i[4*r+3]),
                    .pair_o (node[OFS+r])
                );
            end else begin : g_next
                // previous level holds twice as many rows
                localparam int PREV = 2 * ROWS0 - 4 * ROWS;

                compressor42 i_cpr (
                    .in0_i  (node[PREV+2*r].sum),
                    .in1_i  (node[PREV+2*r].carry),
                    .in2_i  (node[PREV+2*r+1].sum),
                    .in3_i  (node[PREV+2*r+1].carry),
                    .pair_o (node[OFS+r])
                );
            end
        end
    end

    // last level has a single row
    assign pair_o = node[NODES-1];

endmodule

/* cla_adder.sv */
//----------------------------
// final carry-lookahead adder, product width
// 4-bit lookahead groups, group carries ripple upward
//----------------------------
`timescale 1ns/1ps

module cla_adder (
    input  booth_mul_pkg::product_t op_a_i,
    input  booth_mul_pkg::product_t op_b_i,
    output booth_mul_pkg::product_t sum_o
);

    localparam int PW   = booth_mul_pkg::PROD_WIDTH;
    localparam int NGRP = PW / 4;

    logic [PW-1:0] gen;
    logic [PW-1:0] prop;
    logic [PW-1:0] carry;

    assign gen  = op_a_i & op_b_i;
    assign prop = op_a_i ^ op_b_i;

    assign carry[0] = 1'b0;

    for (genvar k = 0; k < NGRP; k++) begin : g_grp
        localparam int B = 4 * k;

        // lookahead inside the group from its carry-in
        assign carry[B+1] = gen[B] | (prop[B] & carry[B]);
        assign carry[B+2] = gen[B+1] | (prop[B+1] & gen[B])
                          | (prop[B+1] & prop[B] & carry[B]);
        assign carry[B+3] = gen[B+2] | (prop[B+2] & gen[B+1])
                          | (prop[B+2] & prop[B+1] & gen[B])
                          | (prop[B+2] & prop[B+1] & prop[B] & carry[B]);

        // group carry into the next group, none out of the top
        if (k < NGRP - 1) begin : g_link
            logic grp_gen;
            logic grp_prop;

            assign grp_gen  = gen[B+3] | (prop[B+3] & gen[B+2])
                            | (prop[B+3] & prop[B+2] & gen[B+1])
                            | (prop[B+3] & prop[B+2] & prop[B+1] & gen[B]);
            assign grp_prop = &prop[B+3:B];

            assign carry[B+4] = grp_gen | (grp_prop & carry[B]);
        end
    end

    assign sum_o = prop ^ carry;

endmodule

/* booth_mul_top.sv */
//----------------------------
// signed radix-4 booth multiplier with req/ack handshake
// operands are captured on request, the product is registered one
// edge later and held with ack until the request is dropped
//----------------------------
`timescale 1ns/1ps

module booth_mul_top (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         req_i,
    output logic                         ack_o,
    input  booth_mul_pkg::mul_operands_t operands_i,
    output booth_mul_pkg::product_t      product_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPUTE,
        ST_ACK
    } state_e;

    state_e                        state_q;
    state_e                        state_d;
    logic                          capture;
    booth_mul_pkg::mul_operands_t  operands_q;
    booth_mul_pkg::product_t       product_q;
    booth_mul_pkg::pp_array_t      pp;
    booth_mul_pkg::csa_pair_t      tree_pair;
    booth_mul_pkg::product_t       product_d;

    //----------------------------
    // handshake control
    //----------------------------
    // idle also means ack was low at the last edge
    assign capture = (state_q == ST_IDLE) && req_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (capture) begin
                    state_d = ST_COMPUTE;
                end
            end
            ST_COMPUTE: begin
                state_d = ST_ACK;
            end
            ST_ACK: begin
                // hold until the requester lets go
                if (!req_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            product_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_COMPUTE) begin
                product_q <= product_d;
            end
        end
    end

    // operand register, loaded once per transaction
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            operands_q <= '0;
        end else if (capture) begin
            operands_q <= operands_i;
        end
    end

    assign ack_o     = (state_q == ST_ACK);
    assign product_o = product_q;

    //----------------------------
    // combinational datapath
    //----------------------------
    booth_encoder i_booth_encoder (
        .multiplicand_i (operands_q.multiplicand),
        .multiplier_i   (operands_q.multiplier),
        .pp_o           (pp)
    );

    wallace_tree i_wallace_tree (
        .pp_i   (pp),
        .pair_o (tree_pair)
    );

    cla_adder i_cla_adder (
        .op_a_i (tree_pair.sum),
        .op_b_i (tree_pair.carry),
        .sum_o  (product_d)
    );

endmodule

/* booth_mul_assertions.sv */
//----------------------------
// handshake properties of the booth multiplier top level
// bound into every booth_mul_top instance
//----------------------------
`timescale 1ns/1ps

module booth_mul_assertions (
    input logic                    clk_i,
    input logic                    arst_n_i,
    input logic                    req_i,
    input logic                    ack_i,
    input booth_mul_pkg::product_t product_i
);

    // ack only answers a live request
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack rose without a request");

    // ack is released only once req has gone low
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(ack_i) |-> $past(!req_i))
        else $error("ack fell while req was still high");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ack_i && $past(ack_i)) |-> $stable(product_i))
        else $error("product changed while ack was held");

    assert property (@(posedge clk_i) !arst_n_i |-> !ack_i)
        else $error("ack high during reset");

endmodule

bind booth_mul_top booth_mul_assertions i_assertions (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .ack_i     (ack_o),
    .product_i (product_o)
);

/* tb_booth_mul.sv */
//----------------------------
// directed testbench of the booth multiplier
// runs four-phase req/ack transactions against a signed reference
// product, prints one line per test and a closing count line
//----------------------------
`timescale 1ns/1ps
`include "booth_mul_params.svh"

module tb_booth_mul;

    localparam int W              = `BOOTH_MUL_WIDTH;
    localparam int ACK_LIMIT      = 8;
    localparam int TIMEOUT_CYCLES = 6000;

    localparam booth_mul_pkg::operand_t MIN_VAL = {1'b1, {(W-1){1'b0}}};
    localparam booth_mul_pkg::operand_t MAX_VAL = {1'b0, {(W-1){1'b1}}};
    localparam booth_mul_pkg::operand_t ALT_A   = {(W/2){2'b10}};
    localparam booth_mul_pkg::operand_t ALT_B   = {(W/2){2'b01}};

    logic                         clk_i;
    logic                         arst_n_i;
    logic                         req_i;
    logic                         ack_o;
    booth_mul_pkg::mul_operands_t operands_i;
    booth_mul_pkg::product_t      product_o;

    logic [31:0] lfsr_q = 32'hbf11_9132;
    int          err_cnt = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;

    booth_mul_top i_dut (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .ack_o      (ack_o),
        .operands_i (operands_i),
        .product_o  (product_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // run limit, well above the longest expected test sequence
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    //----------------------------
    // stimulus and reference
    //----------------------------
    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic booth_mul_pkg::operand_t rand_operand();
        booth_mul_pkg::operand_t v;
        v = '0;
        for (int i = 0; i < W; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[i] = lfsr_q[0];
        end
        return v;
    endfunction

    function automatic int rand_bits(input int bits);
        int v;
        v = 0;
        for (int i = 0; i < bits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    // signed product modulo the product width
    function automatic booth_mul_pkg::product_t ref_product(input booth_mul_pkg::operand_t a,
                                                           input booth_mul_pkg::operand_t b);
        booth_mul_pkg::product_t pa;
        booth_mul_pkg::product_t pb;
        pa = booth_mul_pkg::product_t'(a);
        pb = booth_mul_pkg::product_t'(b);
        return pa * pb;
    endfunction

    // one full four-phase transaction, req held for hold extra cycles
    // chained: called on the edge where the last req was sampled low,
    // raises req right there and returns on its own release edge
    task automatic run_txn(input string name, input booth_mul_pkg::operand_t a,
                           input booth_mul_pkg::operand_t b, input int hold,
                           input bit chained);
        booth_mul_pkg::product_t exp_p;
        int                      edges;
        exp_p = ref_product(a, b);
        edges = 0;
        if (!chained) begin
            @(posedge clk_i);
        end
        operands_i <= '{multiplicand: a, multiplier: b};
        req_i      <= 1'b1;
        if (chained) begin
            @(negedge clk_i);
            assert (!ack_o) else begin
                $display("%s: ack still high when the next request was raised", name);
                err_cnt++;
            end
        end
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (!ack_o && edges < ACK_LIMIT);
        assert (ack_o) else begin
            $display("%s: ack never rose within %0d edges of req", name, ACK_LIMIT);
            err_cnt++;
        end
        assert (edges == 2) else begin
            $display("ERR %s latency: expected 2, actual %0d", name, edges);
            err_cnt++;
        end
        assert (product_o == exp_p) else begin
            $display("ERR %s product: expected %h, actual %h", name, exp_p, product_o);
            err_cnt++;
        end
        repeat (hold) begin
            @(posedge clk_i);
            // new operands after capture must not reach the result
            operands_i <= '{multiplicand: rand_operand(), multiplier: rand_operand()};
            @(negedge clk_i);
            assert (ack_o) else begin
                $display("%s: ack dropped while req was still high", name);
                err_cnt++;
            end
            assert (product_o == exp_p) else begin
                $display("ERR %s held product: expected %h, actual %h", name, exp_p, product_o);
                err_cnt++;
            end
        end
        @(posedge clk_i);
        req_i <= 1'b0;
        @(negedge clk_i);
        assert (ack_o) else begin
            $display("%s: ack fell before req was sampled low", name);
            err_cnt++;
        end
        @(posedge clk_i);
        if (!chained) begin
            @(negedge clk_i);
            assert (!ack_o) else begin
                $display("%s: ack still high after req was sampled low", name);
                err_cnt++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, err_cnt - errs_before);
        end
    endtask

    //----------------------------
    // tests
    //----------------------------
    task automatic reset_values();
        int e0;
        e0 = err_cnt;
        @(negedge clk_i);
        assert (!ack_o) else begin
            $display("ERR reset_values ack: expected 0, actual %b", ack_o);
            err_cnt++;
        end
        assert (product_o == '0) else begin
            $display("ERR reset_values product: expected 0, actual %h", product_o);
            err_cnt++;
        end
        report_test("reset_values", e0);
    endtask

    task automatic corner_products();
        int e0;
        e0 = err_cnt;
        run_txn("corner_products", '0, MAX_VAL, 0, 1'b0);
        run_txn("corner_products", booth_mul_pkg::operand_t'(1), '1, 0, 1'b0);
        run_txn("corner_products", '1, '1, 0, 1'b0);
        run_txn("corner_products", MIN_VAL, MIN_VAL, 0, 1'b0);
        run_txn("corner_products", MAX_VAL, MIN_VAL, 0, 1'b0);
        run_txn("corner_products", ALT_A, ALT_B, 0, 1'b0);
        run_txn("corner_products", ALT_A, ALT_A, 0, 1'b0);
        report_test("corner_products", e0);
    endtask

    // latency itself is checked inside every transaction
    task automatic fixed_latency();
        int e0;
        e0 = err_cnt;
        repeat (4) run_txn("fixed_latency", rand_operand(), rand_operand(), 0, 1'b0);
        report_test("fixed_latency", e0);
    endtask

    task automatic random_products();
        int e0;
        e0 = err_cnt;
        repeat (200) run_txn("random_products", rand_operand(), rand_operand(), 0, 1'b0);
        report_test("random_products", e0);
    endtask

    task automatic back_pressure();
        int e0;
        e0 = err_cnt;
        repeat (10) begin
            run_txn("back_pressure", rand_operand(), rand_operand(), rand_bits(3) + 1, 1'b0);
        end
        report_test("back_pressure", e0);
    endtask

    // req goes up again on the same edge at which ack falls
    task automatic back_to_back();
        int e0;
        e0 = err_cnt;
        @(posedge clk_i);
        repeat (10) run_txn("back_to_back", rand_operand(), rand_operand(), 0, 1'b1);
        @(negedge clk_i);
        assert (!ack_o) else begin
            $display("back_to_back: ack still high after the last release");
            err_cnt++;
        end
        report_test("back_to_back", e0);
    endtask

    initial begin
        arst_n_i   <= 1'b0;
        req_i      <= 1'b0;
        operands_i <= '0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;
        reset_values();
        corner_products();
        fixed_latency();
        random_products();
        back_pressure();
        back_to_back();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* booth_mul_top.f */
+incdir+.
booth_mul_pkg.sv
booth_encoder.sv
compressor42.sv
wallace_tree.sv
cla_adder.sv
booth_mul_top.sv
booth_mul_assertions.sv
tb_booth_mul.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_booth_mul
FILELIST   = booth_mul_top.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
